// ==== Makefile ====
# Verilator build and run of the debug ring node testbench

SIM  := obj_dir/Vdbg_ring_node_tb
SRCS := $(wildcard verilog/*.sv dv/*.sv)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): build.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module dbg_ring_node_tb -f build.f

# exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

// ==== build.f ====
verilog/dbg_dii_pkg.sv
verilog/dbg_dii_buffer.sv
verilog/dbg_dii_demux.sv
verilog/dbg_dii_arbiter.sv
verilog/dbg_ring_node.sv
dv/dbg_ring_node_props.sv
dv/dbg_ring_node_tb.sv

// ==== dv/dbg_ring_node_props.sv ====
// concurrent checks on the packet arbiter: stall stability, grant hold, idle after reset
`timescale 1ns/1ps

module dbg_ring_node_props (
  input logic                 clk,
  input logic                 rst,
  input dbg_dii_pkg::dii_flit flit_out,
  input logic                 out_ready,
  // grant of the arbiter, 1 = inject
  input logic                 sel_inject,
  // arbiter state, 1 = locked onto a packet
  input logic                 arb_locked
);

  logic out_fire;

  // flit leaves the arbiter this cycle
  assign out_fire = flit_out.valid && out_ready;

  //////////////////////////////////////////////////
  // output stability
  //////////////////////////////////////////////////

  // stalled flit holds still, header or body
  stall_stable: assert property (@(posedge clk) disable iff (rst)
    flit_out.valid && !out_ready |=> $stable(flit_out))
    else $error("ring output changed while stalled");

  //////////////////////////////////////////////////
  // grant hold
  //////////////////////////////////////////////////

  // non-final transfer keeps the same source
  grant_after_flit: assert property (@(posedge clk) disable iff (rst)
    out_fire && !flit_out.last |=> $stable(sel_inject))
    else $error("arbiter grant moved after a non-final flit");

  // stalled mid-packet, grant stays put
  grant_while_locked: assert property (@(posedge clk) disable iff (rst)
    arb_locked && !out_fire |=> $stable(sel_inject))
    else $error("arbiter grant moved while locked and stalled");

  //////////////////////////////////////////////////
  // reset
  //////////////////////////////////////////////////

  // nothing offered right after a reset cycle
  idle_after_reset: assert property (@(posedge clk)
    rst |=> !flit_out.valid)
    else $error("arbiter output valid right after reset");

endmodule

// ==== dv/dbg_ring_node_tb.sv ====
// ring node testbench: clock, reset, packet stimulus, routing model, scoreboards, watchdog
`timescale 1ns/1ps

module dbg_ring_node_tb;
  import dbg_dii_pkg::*;

  //////////////////////////////////////////////////
  // run setup
  //////////////////////////////////////////////////

  localparam dii_id_t node_id       = 8'h2A;
  localparam int      clk_half      = 20;
  localparam int      n_ring_pkts   = 40;
  localparam int      n_inject_pkts = 30;
  // stalled packet plus both random streams
  localparam int      n_pkts        = 1 + n_ring_pkts + n_inject_pkts;
  // 8 flits, 4 cycles each, plus slack for the quiet window
  localparam int      timeout_ns    = (n_pkts * 8 * 4 + 500) * 2 * clk_half;

  // where a ring packet should come out
  typedef enum logic {
    port_local,
    port_ring
  } port_t;

  logic          clk;
  logic          rst;
  dii_flit       ring_in;
  logic          ring_in_ready;
  dii_flit       ring_out;
  logic          ring_out_ready;
  dii_flit       local_in;
  logic          local_in_ready;
  dii_flit       local_out;
  logic          local_out_ready;
  dbg_pkt_size_t ring_pkt_size;

  // outputs held stalled while set
  bit            hold_outputs;
  int            stall_len;

  // expected flits per output stream
  dii_flit       local_q[$];
  dii_flit       fwd_q[$];
  dii_flit       inject_q[$];

  dbg_ring_node #(
    .node_id (node_id)
  ) u_dbg_ring_node (
    .clk             (clk),
    .rst             (rst),
    .ring_in         (ring_in),
    .ring_in_ready   (ring_in_ready),
    .ring_out        (ring_out),
    .ring_out_ready  (ring_out_ready),
    .local_in        (local_in),
    .local_in_ready  (local_in_ready),
    .local_out       (local_out),
    .local_out_ready (local_out_ready),
    .ring_pkt_size   (ring_pkt_size)
  );

  // arbiter checks, state encodes locked as 1
  bind dbg_dii_arbiter dbg_ring_node_props u_props (
    .clk        (clk),
    .rst        (rst),
    .flit_out   (flit_out),
    .out_ready  (out_ready),
    .sel_inject (sel_inject),
    .arb_locked (state)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_half) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // reference model and checks
  //////////////////////////////////////////////////

  // header dest equal to our id goes local, all else back on the ring
  function automatic port_t route_of(input dii_data_t header);
    if (header[7:0] == node_id) begin
      return port_local;
    end
    return port_ring;
  endfunction

  // any address except this node
  function automatic dii_id_t pick_other_id();
    dii_id_t id;
    do begin
      id = dii_id_t'($urandom);
    end while (id == node_id);
    return id;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_flit(input string name, input dii_flit got, input dii_flit exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0d ns: %s expected %h got %h",
                         $time, name, exp, got));
    end
  endtask

  task automatic check_size(input string name, input dbg_pkt_size_t got,
                            input dbg_pkt_size_t exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0d ns: %s expected %0d got %0d",
                         $time, name, exp, got));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0d ns: %s expected %b got %b",
                         $time, name, exp, got));
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  task automatic put_flit(input bit inject, input dii_flit f);
    if (inject) begin
      local_in = f;
    end else begin
      ring_in = f;
    end
  endtask

  // one packet on ring_in or local_in, entered and left on a falling edge
  task automatic send_packet(input bit inject, input dii_id_t dest, input dii_id_t src,
                             input int len, input bit early_check);
    dii_flit f;
    dii_flit idle_flit;
    bit      accepted;
    bit      to_local;
    idle_flit = '0;
    to_local  = !inject && (route_of({src, dest}) == port_local);
    for (int i = 0; i < len; i++) begin
      f.valid = 1'b1;
      f.last  = (i == len - 1);
      f.data  = (i == 0) ? {src, dest} : dii_data_t'($urandom);
      // expected copy, routed on the header
      if (inject) begin
        inject_q.push_back(f);
      end else if (to_local) begin
        local_q.push_back(f);
      end else begin
        fwd_q.push_back(f);
      end
      // occasional gap inside the packet
      if (i > 0 && $urandom_range(3, 0) == 0) begin
        put_flit(inject, idle_flit);
        @(negedge clk);
      end
      // incomplete packet must stay hidden
      if (early_check) begin
        check_bit("ring_out.valid", ring_out.valid, 1'b0);
        check_bit("local_out.valid", local_out.valid, 1'b0);
        check_size("ring_pkt_size", ring_pkt_size, '0);
      end
      put_flit(inject, f);
      accepted = 1'b0;
      while (!accepted) begin
        @(posedge clk);
        accepted = inject ? local_in_ready : ring_in_ready;
      end
      @(negedge clk);
    end
    put_flit(inject, idle_flit);
  endtask

  // random back-pressure on both outputs
  task automatic drive_ready();
    forever begin
      @(negedge clk);
      if (hold_outputs) begin
        ring_out_ready  = 1'b0;
        local_out_ready = 1'b0;
      end else begin
        ring_out_ready  = ($urandom_range(9, 0) < 7);
        local_out_ready = ($urandom_range(9, 0) < 6);
      end
    end
  endtask

  //////////////////////////////////////////////////
  // scoreboards
  //////////////////////////////////////////////////

  // header source picks the stream, kept to the end of the packet
  task automatic ring_out_monitor();
    bit      mid_pkt = 1'b0;
    bit      from_inject = 1'b0;
    dii_flit exp;
    forever begin
      @(posedge clk);
      if (!rst && ring_out.valid && ring_out_ready) begin
        if (!mid_pkt) begin
          from_inject = (ring_out.data[15:8] == node_id);
        end
        if (from_inject) begin
          if (inject_q.size() == 0) begin
            fail_run("injected flit on ring_out with no injected packet pending");
          end
          exp = inject_q.pop_front();
        end else begin
          if (fwd_q.size() == 0) begin
            fail_run("forwarded flit on ring_out with no ring packet pending");
          end
          exp = fwd_q.pop_front();
        end
        check_flit("ring_out", ring_out, exp);
        mid_pkt = !ring_out.last;
      end
    end
  endtask

  task automatic local_out_monitor();
    dii_flit exp;
    forever begin
      @(posedge clk);
      if (!rst && local_out.valid && local_out_ready) begin
        if (local_q.size() == 0) begin
          fail_run("flit on local_out with no local packet pending");
        end
        exp = local_q.pop_front();
        check_flit("local_out", local_out, exp);
      end
    end
  endtask

  task automatic watchdog();
    #(timeout_ns);
    fail_run($sformatf("timeout, traffic not finished after %0d ns", timeout_ns));
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    rst             = 1'b1;
    ring_in         = '0;
    local_in        = '0;
    ring_out_ready  = 1'b0;
    local_out_ready = 1'b0;
    hold_outputs    = 1'b1;
    void'($urandom(50354));
    fork
      drive_ready();
      ring_out_monitor();
      local_out_monitor();
      watchdog();
    join_none

    // two clocks of reset, released on a falling edge
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // idle node after reset
    check_bit("ring_out.valid", ring_out.valid, 1'b0);
    check_bit("local_out.valid", local_out.valid, 1'b0);
    check_bit("ring_in_ready", ring_in_ready, 1'b1);
    check_bit("local_in_ready", local_in_ready, 1'b1);
    check_size("ring_pkt_size", ring_pkt_size, '0);

    // one forwarded packet into stalled outputs
    stall_len = $urandom_range(8, 1);
    send_packet(1'b0, pick_other_id(), pick_other_id(), stall_len, 1'b1);
    check_size("ring_pkt_size", ring_pkt_size, dbg_pkt_size_t'(stall_len));
    check_bit("ring_out.valid", ring_out.valid, 1'b1);
    check_bit("local_out.valid", local_out.valid, 1'b0);
    // release on a rising edge, ready driver picks it up next fall
    @(posedge clk);
    hold_outputs = 1'b0;
    @(negedge clk);

    // both inputs busy at once
    fork
      begin : ring_traffic
        dii_id_t dest;
        for (int p = 0; p < n_ring_pkts; p++) begin
          dest = ($urandom_range(9, 0) < 4) ? node_id : pick_other_id();
          send_packet(1'b0, dest, pick_other_id(), $urandom_range(8, 1), 1'b0);
          repeat ($urandom_range(2, 0)) @(negedge clk);
        end
      end
      begin : inject_traffic
        for (int p = 0; p < n_inject_pkts; p++) begin
          send_packet(1'b1, pick_other_id(), node_id, $urandom_range(8, 1), 1'b0);
          repeat ($urandom_range(3, 0)) @(negedge clk);
        end
      end
    join

    // drain everything still in flight, a lost flit runs into the watchdog
    while (local_q.size() != 0 || fwd_q.size() != 0 || inject_q.size() != 0) begin
      @(posedge clk);
    end
    // quiet window, a duplicate would hit an empty queue
    repeat (20) @(negedge clk);
    check_bit("ring_out.valid", ring_out.valid, 1'b0);
    check_bit("local_out.valid", local_out.valid, 1'b0);
    check_size("ring_pkt_size", ring_pkt_size, '0);

    $display("Everything OK");
    $finish;
  end

endmodule

// ==== verilog/dbg_dii_arbiter.sv ====
// dii packet arbiter: round-robin merge of forward and injected packets
`timescale 1ns/1ps

module dbg_dii_arbiter (
  input  logic                 clk,
  input  logic                 rst,
  input  dbg_dii_pkg::dii_flit fwd_flit,
  output logic                 fwd_ready,
  input  dbg_dii_pkg::dii_flit inject_flit,
  output logic                 inject_ready,
  output dbg_dii_pkg::dii_flit flit_out,
  input  logic                 out_ready
);
  import dbg_dii_pkg::*;

  // locked while a packet is offered or partly sent
  typedef enum logic {
    idle,
    locked
  } arb_state_t;

  arb_state_t state;

  // winner of the latest packet, 1 = inject
  // also the grant while locked
  logic       last_inject;

  // choice at a packet boundary
  logic       pick_inject;

  // source driving the output this cycle
  logic       sel_inject;
  logic       out_fire;

  //////////////////////////////////////////////////
  // grant
  //////////////////////////////////////////////////

  // contention goes to the side not served last
  always_comb begin
    if (fwd_flit.valid && inject_flit.valid) begin
      pick_inject = !last_inject;
    end else begin
      pick_inject = inject_flit.valid;
    end
  end

  // no switching inside a packet
  assign sel_inject = (state == locked) ? last_inject : pick_inject;

  //////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////

  // mux carries valid of the granted side only
  assign flit_out = sel_inject ? inject_flit : fwd_flit;

  // loser sees ready low
  assign fwd_ready    = out_ready && !sel_inject;
  assign inject_ready = out_ready && sel_inject;

  assign out_fire = flit_out.valid && out_ready;

  //////////////////////////////////////////////////
  // lock state
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= idle;
      last_inject <= 1'b0;
    end else begin
      // an offered header records the winner, stalled or not
      if (state == idle && flit_out.valid) begin
        last_inject <= sel_inject;
      end
      // release at the last flit, hold the grant otherwise
      if (out_fire && flit_out.last) begin
        state <= idle;
      end else if (flit_out.valid) begin
        state <= locked;
      end
    end
  end

endmodule

// ==== verilog/dbg_dii_buffer.sv ====
// dii flit buffer: shift register, optional full-packet hold, head packet size
`timescale 1ns/1ps

module dbg_dii_buffer #(
  // depth in flits, up to 15 since the fill count uses the size type
  parameter int buf_size    = 4,
  // hold output valid until a whole packet is stored
  parameter bit full_packet = 1'b0
) (
  input  logic                       clk,
  input  logic                       rst,
  input  dbg_dii_pkg::dii_flit       flit_in,
  output logic                       flit_in_ready,
  output dbg_dii_pkg::dii_flit       flit_out,
  input  logic                       flit_out_ready,
  output dbg_dii_pkg::dbg_pkt_size_t packet_size
);
  import dbg_dii_pkg::*;

  // storage, newest at index 0, oldest at count-1
  dii_flit [buf_size-1:0] data;

  // number of occupied entries
  dbg_pkt_size_t          count;

  // index of the oldest entry
  dbg_pkt_size_t          rd_idx;

  // head packet may be presented
  logic                   head_valid;

  logic                   in_fire;
  logic                   out_fire;

  //////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////

  // stall only when every entry is taken
  assign flit_in_ready = (count != dbg_pkt_size_t'(buf_size));
  assign in_fire       = flit_in.valid && flit_in_ready;
  assign out_fire      = flit_out.valid && flit_out_ready;

  // empty buffer points at entry 0, valid is low anyway
  assign rd_idx = (count == '0) ? '0 : count - 1'b1;

  // fill level
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else begin
      case ({in_fire, out_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // shift in at the bottom
  // on a simultaneous read the oldest moves up one and drops out of range
  always_ff @(posedge clk) begin
    if (in_fire) begin
      data <= {data[buf_size-2:0], flit_in};
    end
  end

  // oldest entry, valid gated by fill and packet state
  always_comb begin
    flit_out       = data[rd_idx];
    flit_out.valid = (count != '0) && head_valid;
  end

  //////////////////////////////////////////////////
  // packet tracking
  //////////////////////////////////////////////////

  if (full_packet) begin : g_full
    // last marks, shifted along with the flits
    logic [buf_size-1:0] last_q;
    logic                head_found;
    // position of the oldest stored packet end
    dbg_pkt_size_t       head_end;

    always_ff @(posedge clk) begin
      if (in_fire) begin
        last_q <= {last_q[buf_size-2:0], flit_in.last};
      end
    end

    // highest occupied entry with last set ends the oldest packet
    // ascending scan, so the final hit wins
    always_comb begin
      head_found = 1'b0;
      head_end   = '0;
      for (int i = 0; i < buf_size; i++) begin
        if (last_q[i] && (i < count)) begin
          head_found = 1'b1;
          head_end   = dbg_pkt_size_t'(i);
        end
      end
    end

    // present only once the head packet is complete
    assign head_valid  = head_found;
    // entries count-1 down to head_end
    assign packet_size = head_found ? (count - head_end) : '0;
  end else begin : g_plain
    // plain fifo, one cycle through
    assign head_valid  = 1'b1;
    assign packet_size = '0;
  end

endmodule

// ==== verilog/dbg_dii_demux.sv ====
// dii packet demux: header destination decode, local or forward steering
`timescale 1ns/1ps

module dbg_dii_demux #(
  // address of this node
  parameter dbg_dii_pkg::dii_id_t node_id = 8'h00
) (
  input  logic                 clk,
  input  logic                 rst,
  input  dbg_dii_pkg::dii_flit flit_in,
  output logic                 flit_in_ready,
  output dbg_dii_pkg::dii_flit local_flit,
  input  logic                 local_ready,
  output dbg_dii_pkg::dii_flit fwd_flit,
  input  logic                 fwd_ready
);
  import dbg_dii_pkg::*;

  // idle means the next flit is a header
  typedef enum logic {
    idle,
    in_packet
  } demux_state_t;

  demux_state_t state;

  // route latched from the header, 1 = local
  logic         route_local_q;

  // destination field of the current flit, meaningful on a header
  dii_id_t      hdr_dest;
  logic         hdr_local;

  // route for the current flit
  logic         sel_local;
  logic         in_fire;

  //////////////////////////////////////////////////
  // route select
  //////////////////////////////////////////////////

  assign hdr_dest  = flit_in.data[7:0];
  assign hdr_local = (hdr_dest == node_id);

  // header decides directly, body flits follow the latch
  assign sel_local = (state == idle) ? hdr_local : route_local_q;

  // payload goes to both, valid only to the chosen one
  always_comb begin
    local_flit       = flit_in;
    local_flit.valid = flit_in.valid && sel_local;
    fwd_flit         = flit_in;
    fwd_flit.valid   = flit_in.valid && !sel_local;
  end

  // back-pressure only from the selected port
  assign flit_in_ready = sel_local ? local_ready : fwd_ready;
  assign in_fire       = flit_in.valid && flit_in_ready;

  //////////////////////////////////////////////////
  // packet framing
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= idle;
      route_local_q <= 1'b0;
    end else if (in_fire) begin
      // keep the header route for the body
      if (state == idle) begin
        route_local_q <= hdr_local;
      end
      // single flit packet stays idle
      if (flit_in.last) begin
        state <= idle;
      end else begin
        state <= in_packet;
      end
    end
  end

endmodule

// ==== verilog/dbg_dii_pkg.sv ====
// dii flit type, payload / id / packet size types, node buffer depths

package dbg_dii_pkg;

  //////////////////////////////////////////////////
  // payload and addressing
  //////////////////////////////////////////////////

  // flit payload width
  localparam int dii_data_w = 16;

  // one flit payload word
  typedef logic [dii_data_w-1:0] dii_data_t;

  // node address
  // header flit: dest in bits 7..0, source in bits 15..8
  typedef logic [7:0] dii_id_t;

  // unit moved on every link, ready travels beside it
  typedef struct packed {
    logic      valid;
    logic      last;
    dii_data_t data;
  } dii_flit;

  //////////////////////////////////////////////////
  // node buffering
  //////////////////////////////////////////////////

  // ring input depth, also the longest legal packet
  localparam int ring_buf_size = 8;

  // local injection depth
  localparam int local_buf_size = 8;

  // packet length in flits, 0 means no complete packet
  typedef logic [3:0] dbg_pkt_size_t;

endpackage

// ==== verilog/dbg_ring_node.sv ====
// debug ring node top: input buffers, destination demux, packet arbiter
`timescale 1ns/1ps

module dbg_ring_node #(
  // address of this node
  parameter dbg_dii_pkg::dii_id_t node_id = 8'h00
) (
  input  logic                       clk,
  input  logic                       rst,
  // from the ring
  input  dbg_dii_pkg::dii_flit       ring_in,
  output logic                       ring_in_ready,
  // to the ring
  output dbg_dii_pkg::dii_flit       ring_out,
  input  logic                       ring_out_ready,
  // injected by the local debug module
  input  dbg_dii_pkg::dii_flit       local_in,
  output logic                       local_in_ready,
  // delivered to the local debug module
  output dbg_dii_pkg::dii_flit       local_out,
  input  logic                       local_out_ready,
  // length of the packet at the ring buffer head
  output dbg_dii_pkg::dbg_pkt_size_t ring_pkt_size
);
  import dbg_dii_pkg::*;

  // ring buffer to demux
  dii_flit ring_buf_flit;
  logic    ring_buf_ready;

  // demux to arbiter
  dii_flit fwd_flit;
  logic    fwd_ready;

  // injection buffer to arbiter
  dii_flit inject_flit;
  logic    inject_ready;

  //////////////////////////////////////////////////
  // input side
  //////////////////////////////////////////////////

  // whole packets only, so the demux sees complete frames
  dbg_dii_buffer #(
    .buf_size    (ring_buf_size),
    .full_packet (1'b1)
  ) u_ring_buf (
    .clk            (clk),
    .rst            (rst),
    .flit_in        (ring_in),
    .flit_in_ready  (ring_in_ready),
    .flit_out       (ring_buf_flit),
    .flit_out_ready (ring_buf_ready),
    .packet_size    (ring_pkt_size)
  );

  // injected packets, size not reported
  dbg_dii_buffer #(
    .buf_size    (local_buf_size),
    .full_packet (1'b1)
  ) u_inject_buf (
    .clk            (clk),
    .rst            (rst),
    .flit_in        (local_in),
    .flit_in_ready  (local_in_ready),
    .flit_out       (inject_flit),
    .flit_out_ready (inject_ready),
    .packet_size    ()
  );

  //////////////////////////////////////////////////
  // processing and output side
  //////////////////////////////////////////////////

  dbg_dii_demux #(
    .node_id (node_id)
  ) u_demux (
    .clk           (clk),
    .rst           (rst),
    .flit_in       (ring_buf_flit),
    .flit_in_ready (ring_buf_ready),
    .local_flit    (local_out),
    .local_ready   (local_out_ready),
    .fwd_flit      (fwd_flit),
    .fwd_ready     (fwd_ready)
  );

  // forward and injected traffic share the ring output
  dbg_dii_arbiter u_arbiter (
    .clk          (clk),
    .rst          (rst),
    .fwd_flit     (fwd_flit),
    .fwd_ready    (fwd_ready),
    .inject_flit  (inject_flit),
    .inject_ready (inject_ready),
    .flit_out     (ring_out),
    .out_ready    (ring_out_ready)
  );

endmodule
